//--- design/exec_pkg.sv
// package with the ALU operation codes and instruction layouts shared by the execute slice.
`default_nettype none

package exec_pkg;

	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_MUL,
		ALU_MULH,
		ALU_MULHSU,
		ALU_MULHU,
		ALU_DIV,
		ALU_DIVU,
		ALU_REM,
		ALU_REMU
	} alu_op_t;

	// three readings of the same 32-bit instruction word.
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_view;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_view;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_view;
	} instr_word_u;

	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
	localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;

	// op, operand_a, operand_b, rd.
	localparam int ENTRY_W = 5 + 32 + 32 + 5;

	function automatic logic is_div_op(alu_op_t op);
		return op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
	endfunction

endpackage

`default_nettype wire

//--- design/instr_decoder.sv
// decodes one strobed RV32IM instruction into a registered queue entry for the execute slice.
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          instr_valid,
	input  wire  [31:0]                  instr,
	input  wire  [31:0]                  pc,
	input  wire  [31:0]                  rs1_val,
	input  wire  [31:0]                  rs2_val,
	output logic                         dec_valid,
	output logic [exec_pkg::ENTRY_W-1:0] dec_entry
);
	import exec_pkg::*;

	instr_word_u iw;
	alu_op_t     op;
	logic [31:0] opa;
	logic [31:0] opb;
	logic        supported;
	logic        alt;

	assign iw  = instr;
	assign alt = (iw.r_view.funct7 == FUNCT7_ALT);

	always_comb begin
		supported = 1'b0;
		op        = ALU_ADD;
		opa       = rs1_val;
		opb       = rs2_val;
		case (iw.r_view.opcode)
			OPC_OP: begin
				supported = 1'b1;
				if (iw.r_view.funct7 == FUNCT7_MULDIV) begin
					// funct3 order matches the enum from MUL on.
					op = alu_op_t'(5'(ALU_MUL) + 5'(iw.r_view.funct3));
				end else begin
					case (iw.r_view.funct3)
						3'd0: op = alt ? ALU_SUB : ALU_ADD;
						3'd1: op = ALU_SLL;
						3'd2: op = ALU_SLT;
						3'd3: op = ALU_SLTU;
						3'd4: op = ALU_XOR;
						3'd5: op = alt ? ALU_SRA : ALU_SRL;
						3'd6: op = ALU_OR;
						default: op = ALU_AND;
					endcase
				end
			end
			OPC_OP_IMM: begin
				supported = 1'b1;
				opb = {{20{iw.i_view.imm[11]}}, iw.i_view.imm};
				case (iw.i_view.funct3)
					3'd0: op = ALU_ADD;
					3'd1: op = ALU_SLL;
					3'd2: op = ALU_SLT;
					3'd3: op = ALU_SLTU;
					3'd4: op = ALU_XOR;
					3'd5: op = alt ? ALU_SRA : ALU_SRL;
					3'd6: op = ALU_OR;
					default: op = ALU_AND;
				endcase
			end
			OPC_LUI: begin
				supported = 1'b1;
				opa = 32'd0;
				opb = {iw.u_view.imm, 12'd0};
			end
			OPC_AUIPC: begin
				supported = 1'b1;
				opa = pc;
				opb = {iw.u_view.imm, 12'd0};
			end
			default: supported = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid && supported;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec_entry <= {op, opa, opb, iw.r_view.rd};
		end
	end

endmodule

`default_nettype wire

//--- design/issue_fifo.sv
// circular queue of decoded operations between the decoder and the ALU unit, dropping on full.
`timescale 1ns/10ps
`default_nettype none

module issue_fifo #(
	parameter int depth = 4
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          push,
	input  wire  [exec_pkg::ENTRY_W-1:0] push_entry,
	input  wire                          pop,
	output logic [exec_pkg::ENTRY_W-1:0] head_entry,
	output logic                         not_empty,
	output logic                         overflow
);
	import exec_pkg::*;

	localparam int PTR_W = $clog2(depth);
	localparam int CNT_W = $clog2(depth + 1);

	logic [ENTRY_W-1:0] mem [depth];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               full;
	logic               do_push;

	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
		return (p == PTR_W'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full       = (count == CNT_W'(depth));
	assign not_empty  = (count != '0);
	assign head_entry = mem[rd_ptr];
	// a pop in the same cycle frees the slot for the push.
	assign do_push    = push && (!full || pop);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push) wr_ptr <= next_ptr(wr_ptr);
			if (pop) rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !pop) count <= count + 1'b1;
			else if (!do_push && pop) count <= count - 1'b1;
			if (push && !do_push) overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= push_entry;
	end

endmodule

`default_nettype wire

//--- design/serial_divider.sv
// 33-cycle restoring divider for DIV, DIVU, REM and REMU, started by a single-cycle strobe.
`timescale 1ns/10ps
`default_nettype none

module serial_divider (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         start,
	input  wire  [31:0] dividend,
	input  wire  [31:0] divisor,
	input  wire         is_signed,
	input  wire         want_rem,
	output logic        done,
	output logic [31:0] quotient_or_rem
);
	logic        busy;
	logic [5:0]  cnt;
	logic [31:0] quo_q;
	logic [31:0] rem_q;
	logic [31:0] dvs_q;
	logic [31:0] dvd_q;
	logic        neg_quo;
	logic        neg_rem;
	logic        sel_rem;
	logic        by_zero;
	logic [32:0] shifted;
	logic [32:0] trial;
	logic [31:0] quo_fix;
	logic [31:0] rem_fix;

	assign done    = busy && (cnt == 6'd32);
	assign shifted = {rem_q, quo_q[31]};
	assign trial   = shifted - {1'b0, dvs_q};

	// remainder follows the dividend sign.
	assign quo_fix = neg_quo ? -quo_q : quo_q;
	assign rem_fix = neg_rem ? -rem_q : rem_q;
	// most negative over minus one falls out of the magnitudes.
	assign quotient_or_rem = by_zero ? (sel_rem ? dvd_q : 32'hffff_ffff)
	                                 : (sel_rem ? rem_fix : quo_fix);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (!busy) begin
			busy <= start;
			cnt  <= '0;
		end else if (done) begin
			busy <= 1'b0;
		end else begin
			cnt <= cnt + 6'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && start) begin
			quo_q   <= (is_signed && dividend[31]) ? -dividend : dividend;
			dvs_q   <= (is_signed && divisor[31]) ? -divisor : divisor;
			rem_q   <= '0;
			dvd_q   <= dividend;
			neg_quo <= is_signed && (dividend[31] ^ divisor[31]);
			neg_rem <= is_signed && dividend[31];
			sel_rem <= want_rem;
			by_zero <= (divisor == 32'd0);
		end else if (busy && !done) begin
			rem_q <= trial[32] ? shifted[31:0] : trial[31:0];
			quo_q <= {quo_q[30:0], ~trial[32]};
		end
	end

endmodule

`default_nettype wire

//--- design/alu_unit.sv
// pops the queue head, computes single-cycle results and sequences the divider for divides.
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire  [exec_pkg::ENTRY_W-1:0] head_entry,
	input  wire                          not_empty,
	output logic                         pop,
	output logic                         result_valid,
	output logic [31:0]                  result,
	output logic [4:0]                   result_rd
);
	import exec_pkg::*;

	alu_op_t     op;
	logic [31:0] a;
	logic [31:0] b;
	logic [4:0]  rd;
	logic        dividing;
	logic [4:0]  rd_hold;
	logic [31:0] alu_res;
	logic [63:0] prod_ss;
	logic [63:0] prod_su;
	logic [63:0] prod_uu;
	logic        div_start;
	logic        div_signed;
	logic        div_rem;
	logic        div_done;
	logic [31:0] div_result;

	assign op = alu_op_t'(head_entry[73:69]);
	assign a  = head_entry[68:37];
	assign b  = head_entry[36:5];
	assign rd = head_entry[4:0];

	assign pop        = !dividing && not_empty;
	assign div_start  = pop && is_div_op(op);
	assign div_signed = (op == ALU_DIV) || (op == ALU_REM);
	assign div_rem    = (op == ALU_REM) || (op == ALU_REMU);

	// sign extension to 64 bits gives each product flavour.
	assign prod_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};
	assign prod_su = {{32{a[31]}}, a} * {32'd0, b};
	assign prod_uu = {32'd0, a} * {32'd0, b};

	always_comb begin
		case (op)
			ALU_ADD:    alu_res = a + b;
			ALU_SUB:    alu_res = a - b;
			ALU_SLL:    alu_res = a << b[4:0];
			ALU_SLT:    alu_res = {31'd0, $signed(a) < $signed(b)};
			ALU_SLTU:   alu_res = {31'd0, a < b};
			ALU_XOR:    alu_res = a ^ b;
			ALU_SRL:    alu_res = a >> b[4:0];
			ALU_SRA:    alu_res = $signed(a) >>> b[4:0];
			ALU_OR:     alu_res = a | b;
			ALU_AND:    alu_res = a & b;
			ALU_MUL:    alu_res = prod_ss[31:0];
			ALU_MULH:   alu_res = prod_ss[63:32];
			ALU_MULHSU: alu_res = prod_su[63:32];
			ALU_MULHU:  alu_res = prod_uu[63:32];
			default:    alu_res = 32'd0;
		endcase
	end

	serial_divider u_serial_divider (
		.clk             (clk),
		.rst_n           (rst_n),
		.start           (div_start),
		.dividend        (a),
		.divisor         (b),
		.is_signed       (div_signed),
		.want_rem        (div_rem),
		.done            (div_done),
		.quotient_or_rem (div_result)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dividing     <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= (dividing && div_done) || (pop && !div_start);
			if (dividing && div_done) dividing <= 1'b0;
			else if (div_start) dividing <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (div_start) rd_hold <= rd;
		if (dividing && div_done) begin
			result    <= div_result;
			result_rd <= rd_hold;
		end else if (pop && !div_start) begin
			result    <= alu_res;
			result_rd <= rd;
		end
	end

endmodule

`default_nettype wire

//--- design/exec_top.sv
// top level of the execute slice joining the decoder, the issue queue and the ALU unit.
`timescale 1ns/10ps
`default_nettype none

module exec_top #(
	parameter int depth = 4
) (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         instr_valid,
	input  wire  [31:0] instr,
	input  wire  [31:0] pc,
	input  wire  [31:0] rs1_val,
	input  wire  [31:0] rs2_val,
	output logic        result_valid,
	output logic [31:0] result,
	output logic [4:0]  result_rd,
	output logic        overflow
);
	import exec_pkg::*;

	logic               dec_valid;
	logic [ENTRY_W-1:0] dec_entry;
	logic               pop;
	logic [ENTRY_W-1:0] head_entry;
	logic               not_empty;

	instr_decoder u_instr_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.rs1_val     (rs1_val),
		.rs2_val     (rs2_val),
		.dec_valid   (dec_valid),
		.dec_entry   (dec_entry)
	);

	issue_fifo #(.depth(depth)) u_issue_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (dec_valid),
		.push_entry (dec_entry),
		.pop        (pop),
		.head_entry (head_entry),
		.not_empty  (not_empty),
		.overflow   (overflow)
	);

	alu_unit u_alu_unit (
		.clk          (clk),
		.rst_n        (rst_n),
		.head_entry   (head_entry),
		.not_empty    (not_empty),
		.pop          (pop),
		.result_valid (result_valid),
		.result       (result),
		.result_rd    (result_rd)
	);

endmodule

`default_nettype wire

//--- dv/exec_checker.sv
// protocol assertions for the execute slice, attached to exec_top by bind.
`timescale 1ns/10ps
`default_nettype none

module exec_checker (
	input wire       clk,
	input wire       rst_n,
	input wire       instr_valid,
	input wire       result_valid,
	input wire       overflow,
	input wire       pop,
	input wire       not_empty,
	input wire       dec_valid,
	input wire       dividing,
	input wire       div_busy,
	input wire       dec_supported,
	input wire [4:0] dec_op
);
	import exec_pkg::*;

	a_reset_clears: assert property (@(posedge clk)
		!rst_n |=> (!result_valid && !overflow))
		else $error("result_valid or overflow not low after a reset cycle");

	a_overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		overflow |=> overflow)
		else $error("overflow fell without a reset");

	// a pop may start the divider, so it must be idle by then.
	a_pop_divider_idle: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !div_busy)
		else $error("pop while the divider is still busy");

	// decoder, queue and ALU unit all idle.
	a_single_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(instr_valid && dec_supported && !is_div_op(alu_op_t'(dec_op))
			&& !not_empty && !dec_valid && !dividing) |-> ##3 result_valid)
		else $error("single-cycle result did not arrive 3 cycles after instr_valid");

endmodule

bind exec_top exec_checker u_exec_checker (
	.clk           (clk),
	.rst_n         (rst_n),
	.instr_valid   (instr_valid),
	.result_valid  (result_valid),
	.overflow      (overflow),
	.pop           (pop),
	.not_empty     (not_empty),
	.dec_valid     (dec_valid),
	.dividing      (u_alu_unit.dividing),
	.div_busy      (u_alu_unit.u_serial_divider.busy),
	.dec_supported (u_instr_decoder.supported),
	.dec_op        (u_instr_decoder.op)
);

`default_nettype wire

//--- dv/tb_exec.sv
// testbench for the execute slice; sends RV32IM work and checks each result against a model.
`timescale 1ns/10ps
`default_nettype none

module tb_exec;
	import exec_pkg::*;

	localparam int DEPTH = 4;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic [31:0] rs1_val;
	logic [31:0] rs2_val;
	logic        result_valid;
	logic [31:0] result;
	logic [4:0]  result_rd;
	logic        overflow;

	// each entry is {rd, value}.
	logic [36:0] exp_q[$];
	logic [31:0] rng_state;
	string       test_name;

	exec_top #(.depth(DEPTH)) u_exec_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.pc           (pc),
		.rs1_val      (rs1_val),
		.rs2_val      (rs2_val),
		.result_valid (result_valid),
		.result       (result),
		.result_rd    (result_rd),
		.overflow     (overflow)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [31:0] r_word(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd);
		instr_word_u w;
		w = '0;
		w.r_view.funct7 = f7;
		w.r_view.rs1    = 5'd1;
		w.r_view.rs2    = 5'd2;
		w.r_view.funct3 = f3;
		w.r_view.rd     = rd;
		w.r_view.opcode = OPC_OP;
		return w;
	endfunction

	function automatic logic [31:0] i_word(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd);
		instr_word_u w;
		w = '0;
		w.i_view.imm    = imm;
		w.i_view.rs1    = 5'd1;
		w.i_view.funct3 = f3;
		w.i_view.rd     = rd;
		w.i_view.opcode = OPC_OP_IMM;
		return w;
	endfunction

	function automatic logic [31:0] u_word(logic [6:0] opc, logic [19:0] imm, logic [4:0] rd);
		instr_word_u w;
		w.u_view.imm    = imm;
		w.u_view.rd     = rd;
		w.u_view.opcode = opc;
		return w;
	endfunction

	// {supported, value} from the RV32IM rules.
	function automatic logic [32:0] predict(logic [31:0] w, logic [31:0] a, logic [31:0] b,
		logic [31:0] pcv);
		logic [31:0] opb;
		logic [4:0]  sh;
		logic        ovf;
		logic [63:0] ss;
		logic [63:0] su;
		logic [63:0] uu;
		opb = (w[6:0] == OPC_OP) ? b : {{20{w[31]}}, w[31:20]};
		sh  = opb[4:0];
		ovf = (a == 32'h8000_0000) && (opb == 32'hffff_ffff);
		ss  = longint'(int'(a)) * longint'(int'(opb));
		su  = longint'(int'(a)) * longint'({32'd0, opb});
		uu  = {32'd0, a} * {32'd0, opb};
		if (w[6:0] == OPC_LUI) return {1'b1, w[31:12], 12'd0};
		if (w[6:0] == OPC_AUIPC) return {1'b1, pcv + {w[31:12], 12'd0}};
		if (w[6:0] != OPC_OP && w[6:0] != OPC_OP_IMM) return 33'd0;
		if (w[6:0] == OPC_OP && w[31:25] == FUNCT7_MULDIV) begin
			case (w[14:12])
				3'd0: return {1'b1, ss[31:0]};
				3'd1: return {1'b1, ss[63:32]};
				3'd2: return {1'b1, su[63:32]};
				3'd3: return {1'b1, uu[63:32]};
				3'd4: return {1'b1, (opb == 0) ? 32'hffff_ffff : ovf ? a : 32'(int'(a) / int'(opb))};
				3'd5: return {1'b1, (opb == 0) ? 32'hffff_ffff : a / opb};
				3'd6: return {1'b1, (opb == 0) ? a : ovf ? 32'd0 : 32'(int'(a) % int'(opb))};
				default: return {1'b1, (opb == 0) ? a : a % opb};
			endcase
		end
		case (w[14:12])
			3'd0: return {1'b1, (w[6:0] == OPC_OP && w[30]) ? a - opb : a + opb};
			3'd1: return {1'b1, a << sh};
			3'd2: return {1'b1, 31'd0, int'(a) < int'(opb)};
			3'd3: return {1'b1, 31'd0, a < opb};
			3'd4: return {1'b1, a ^ opb};
			3'd5: return {1'b1, w[30] ? 32'(int'(a) >>> sh) : a >> sh};
			3'd6: return {1'b1, a | opb};
			default: return {1'b1, a & opb};
		endcase
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic send(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b,
		input logic keep);
		logic [31:0] pcv;
		logic [32:0] pred;
		pcv  = next_rand() & 32'hffff_fffc;
		pred = predict(word, a, b, pcv);
		@(negedge clk);
		instr_valid = 1'b1;
		instr       = word;
		pc          = pcv;
		rs1_val     = a;
		rs2_val     = b;
		if (pred[32] && keep) exp_q.push_back({word[11:7], pred[31:0]});
	endtask

	task automatic drain_results(input int limit);
		int waited;
		waited = 0;
		@(negedge clk);
		instr_valid = 1'b0;
		while (exp_q.size() != 0) begin
			if (waited == limit) begin
				stop_with_failure($sformatf("timed out in %s with %0d results missing",
					test_name, exp_q.size()));
			end else begin
				@(negedge clk);
				waited++;
			end
		end
	endtask

	task automatic measure_latency(output int cycles);
		@(negedge clk);
		instr_valid = 1'b0;
		cycles = 1;
		while (!result_valid) begin
			if (cycles == 20) begin
				stop_with_failure("timed out waiting for result_valid");
			end else begin
				@(negedge clk);
				cycles++;
			end
		end
	endtask

	// outputs are stable at the falling edge.
	always @(negedge clk) begin : check_results
		logic [36:0] expected;
		if (rst_n && result_valid) begin
			if (exp_q.size() == 0) begin
				stop_with_failure("result_valid rose with no instruction outstanding");
			end else begin
				expected = exp_q.pop_front();
				assert ({result_rd, result} == expected)
				else stop_with_failure($sformatf(
					"FAILED %s expected rd %0d value %h, actual rd %0d value %h",
					test_name, expected[36:32], expected[31:0], result_rd, result));
			end
		end
	end

	initial begin
		int          lat;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [31:0] corner [5];
		clk         = 1'b0;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		rs1_val     = '0;
		rs2_val     = '0;
		rng_state   = 32'd8;
		corner      = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'd1, 32'd0};
		test_name   = "reset";
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		assert (!result_valid && !overflow)
		else stop_with_failure("result_valid or overflow high after reset");

		test_name = "isolated add";
		send(r_word(7'd0, 3'd0, 5'd3), 32'd100, 32'd23, 1'b1);
		measure_latency(lat);
		assert (lat == 3)
		else stop_with_failure($sformatf("FAILED %s expected latency 3, actual %0d",
			test_name, lat));
		drain_results(20);

		test_name = "base ops";
		for (int i = 0; i < 60; i++) begin
			r  = next_rand();
			f3 = r[2:0];
			if (r[3]) begin
				send(r_word((r[4] && (f3 == 3'd0 || f3 == 3'd5)) ? FUNCT7_ALT : 7'd0, f3, r[9:5]),
					next_rand(), next_rand(), 1'b1);
			end else begin
				imm = (f3 == 3'd1) ? {7'd0, r[14:10]} :
					(f3 == 3'd5) ? {(r[4] ? FUNCT7_ALT : 7'd0), r[14:10]} : r[21:10];
				send(i_word(imm, f3, r[9:5]), next_rand(), next_rand(), 1'b1);
			end
		end
		drain_results(20);

		test_name = "multiply";
		for (int i = 0; i < 25; i++) begin
			for (int k = 0; k < 4; k++) begin
				send(r_word(FUNCT7_MULDIV, 3'(k), 5'(i)), corner[i / 5], corner[i % 5], 1'b1);
				send(r_word(FUNCT7_MULDIV, 3'(k), 5'(i + 1)), next_rand(), next_rand(), 1'b1);
			end
		end
		drain_results(20);

		// each divide is chased by an OR to check ordering.
		test_name = "divide";
		for (int i = 0; i < 24; i++) begin
			r = next_rand();
			a = (i >= 4 && i < 8) ? 32'h8000_0000 : next_rand();
			b = (i < 4) ? 32'd0 : (i < 8) ? 32'hffff_ffff : r >> r[4:0];
			send(r_word(FUNCT7_MULDIV, 3'(4 + i % 4), r[9:5]), a, b, 1'b1);
			send(r_word(7'd0, 3'd6, r[14:10]), next_rand(), next_rand(), 1'b1);
			drain_results(60);
		end

		test_name = "upper immediates";
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			send(u_word(OPC_LUI, r[31:12], r[4:0]), next_rand(), next_rand(), 1'b1);
			send(u_word(i[0] ? 7'b0000011 : 7'b1100011, r[27:8], r[9:5]), r, r, 1'b1);
			send(u_word(OPC_AUIPC, r[27:8], r[14:10]), next_rand(), next_rand(), 1'b1);
		end
		drain_results(20);

		test_name = "overflow";
		for (int i = 0; i < 8; i++) begin
			send(r_word(FUNCT7_MULDIV, 3'd5, 5'(i + 1)), next_rand(),
				(next_rand() >> 20) + 32'd1, i < DEPTH + 1);
		end
		drain_results(250);
		assert (overflow)
		else stop_with_failure("overflow did not rise after the queue filled");

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
design/exec_pkg.sv
design/instr_decoder.sv
design/issue_fifo.sv
design/serial_divider.sv
design/alu_unit.sv
design/exec_top.sv
dv/exec_checker.sv
dv/tb_exec.sv

//--- Makefile
TOP = tb_exec

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim 2>&1 | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then \
		echo "run failed"; exit 1; \
	fi
	@grep -q "SIMULATION PASSED" sim.log || (echo "run did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
